// ==== patt_top.f ====
src/patt_pkg.sv
src/patt_cfg_if.sv
src/patt_cfg_regs.sv
src/rate_strobe.sv
src/patt_gen.sv
src/patt_check.sv
src/patt_top.sv
testbench/patt_top_asserts.sv
testbench/patt_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f patt_top.f --top-module patt_top_tb \
   && ./obj_dir/Vpatt_top_tb \
   || exit 1

// ==== src/patt_cfg_if.sv ====
`timescale 1ns/10ps

interface patt_cfg_if #(
   parameter int dwi = 32
) ();

   // Pattern source halted, status cleared
   logic           pgen_off;
   // Counter or user word
   logic           test_mode;
   // Strobe period, already 1..32
   logic [5:0]     rate_enc;
   // Counter step, already 1..8
   logic [3:0]     inc_enc;
   // User data word, sized to the stream
   logic [dwi-1:0] usr_data;

   // Register block owns every field
   modport regs (
      output pgen_off, test_mode, rate_enc, inc_enc, usr_data
   );

   // Strobe, generator and checker only read
   modport user (
      input pgen_off, test_mode, rate_enc, inc_enc, usr_data
   );

endinterface

// ==== src/patt_cfg_regs.sv ====
`timescale 1ns/10ps

module patt_cfg_regs #(
   parameter int dwi = 32
) (
   input  logic                     clk,
   input  logic                     arst_n,
   // Four-phase register port
   input  logic                     cfg_req,
   input  logic                     cfg_addr,
   input  patt_pkg::patt_cfg_word_t cfg_wdata,
   output logic                     cfg_ack,
   // Settings to the users
   patt_cfg_if.regs                 cfg
);
   import patt_pkg::*;

   // One write per request, on the cycle before ack rises
   logic       wr_stb;
   // Control view of the incoming word
   patt_ctrl_t ctrl;

   assign wr_stb = cfg_req & ~cfg_ack;
   assign ctrl   = cfg_wdata.ctrl;

   // --------------------
   // Handshake
   // --------------------

   // Ack tracks req one cycle late
   // Rises after req rises, falls after req falls
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg_ack <= 1'b0;
      end else begin
         cfg_ack <= cfg_req;
      end
   end

   // --------------------
   // Control fields
   // --------------------

   // Reset state: disabled, counter mode, rate 1, step 1
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg.pgen_off  <= 1'b1;
         cfg.test_mode <= tmode_cnt;
         cfg.rate_enc  <= 6'd1;
         cfg.inc_enc   <= 4'd1;
      end else if (wr_stb && cfg_addr == addr_ctrl) begin
         cfg.pgen_off  <= ctrl.pgen_disable;
         cfg.test_mode <= ctrl.test_mode;
         // Zero rate stands for the slowest, 1/32
         cfg.rate_enc  <= (ctrl.rate == 5'd0) ? 6'd32 : {1'b0, ctrl.rate};
         // Zero step stands for the largest, 8
         cfg.inc_enc   <= (ctrl.inc_step == 3'd0) ? 4'd8 : {1'b0, ctrl.inc_step};
      end
   end

   // --------------------
   // User data
   // --------------------

   // Raw word, zero-extended or cut to the stream width
   always_ff @(posedge clk) begin
      if (wr_stb && cfg_addr == addr_usr) begin
         cfg.usr_data <= dwi'(cfg_wdata.usr);
      end
   end

endmodule

// ==== src/patt_check.sv ====
`timescale 1ns/10ps

module patt_check #(
   parameter int dwi = 32
) (
   input  logic                        clk,
   input  logic                        arst_n,
   // Mode, step and user word
   patt_cfg_if.user                    cfg,
   // Incoming stream, no back-pressure
   input  logic                        rx_valid,
   input  logic [dwi-1:0]              rx_data,
   // Lock status
   output logic                        rx_match,
   // Count of interrupted runs
   output logic [patt_pkg::err_wi-1:0] rx_err_cnt
);
   import patt_pkg::*;

   // --------------------
   // Window
   // --------------------

   // Expected next counter value
   logic [cnt_wi-1:0] ref_cnt;
   // Last word that advanced the window
   logic [dwi-1:0]    last_q;
   // Expected value at stream width
   logic [dwi-1:0]    ref_word;

   // Compare results
   logic match_cur;
   logic match_next;
   logic accept;
   // Error counter at its top value
   logic err_full;

   assign ref_word = dwi'(ref_cnt);

   // New entry of the window
   assign match_next = (rx_data == ref_word);

   // Old entry, a repeat in counter mode
   // In user mode the user word takes its place
   assign match_cur = (cfg.test_mode == tmode_usr) ? (rx_data == cfg.usr_data) :
                                                     (rx_data == last_q);

   assign accept   = match_cur | match_next;
   assign err_full = &rx_err_cnt;

   // --------------------
   // Lock and errors
   // --------------------

   // Disable wins over any word in flight
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ref_cnt    <= '0;
         last_q     <= '0;
         rx_match   <= 1'b0;
         rx_err_cnt <= '0;
      end else if (cfg.pgen_off) begin
         ref_cnt    <= '0;
         rx_match   <= 1'b0;
         rx_err_cnt <= '0;
      end else if (rx_valid) begin
         // Status follows each word one cycle later
         rx_match <= accept;

         if (match_next) begin
            // Slide the window forward
            ref_cnt <= cnt_next(ref_cnt, cfg.inc_enc);
            last_q  <= ref_word;
         end else if (!accept) begin
            // Lost, hunt for the start of the sequence again
            ref_cnt <= '0;
         end

         // Only a run that was locked counts as interrupted
         // Saturates instead of wrapping
         if (rx_match && !accept && !err_full) begin
            rx_err_cnt <= rx_err_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== src/patt_gen.sv ====
`timescale 1ns/10ps

module patt_gen #(
   parameter int dwi = 32
) (
   input  logic           clk,
   input  logic           arst_n,
   // Mode, step and user word
   patt_cfg_if.user       cfg,
   // Rate pulse from the divider
   input  logic           strobe,
   // Outgoing stream
   output logic           tx_valid,
   output logic [dwi-1:0] tx_data
);
   import patt_pkg::*;

   // Pattern counter
   logic [cnt_wi-1:0] cnt_q;
   // Strobe that is allowed through
   logic              fire;

   // Late strobe right after disable is dropped
   assign fire = strobe & ~cfg.pgen_off;

   // --------------------
   // Valid and counter
   // --------------------

   // Valid is the strobe delayed by one clock
   // Counter steps on the cycle after each word
   // So at full rate the first word goes out twice
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_valid <= 1'b0;
         cnt_q    <= '0;
      end else begin
         tx_valid <= fire;
         if (cfg.pgen_off) begin
            cnt_q <= '0;
         end else if (tx_valid) begin
            cnt_q <= cnt_next(cnt_q, cfg.inc_enc);
         end
      end
   end

   // --------------------
   // Data word
   // --------------------

   // Loaded only with a word, held between words
   always_ff @(posedge clk) begin
      if (fire) begin
         if (cfg.test_mode == tmode_cnt) begin
            // Counter zero-extended to the stream width
            tx_data <= dwi'(cnt_q);
         end else begin
            tx_data <= cfg.usr_data;
         end
      end
   end

endmodule

// ==== src/patt_pkg.sv ====
package patt_pkg;

   // --------------------
   // Widths
   // --------------------

   // Pattern counter, starts at zero
   localparam int cnt_wi = 7;
   // Interrupted-run counter
   localparam int err_wi = 16;

   // --------------------
   // Codes
   // --------------------

   // Test mode select
   localparam logic tmode_cnt = 1'b0;
   localparam logic tmode_usr = 1'b1;

   // Register addresses
   localparam logic addr_ctrl = 1'b0;
   localparam logic addr_usr  = 1'b1;

   // --------------------
   // Configuration word
   // --------------------

   // Control fields, bit 0 is the disable bit
   typedef struct packed {
      logic [21:0] pad;
      // Counter step, 0 means 8
      logic [2:0]  inc_step;
      // Strobe period in cycles, 0 means 32
      logic [4:0]  rate;
      logic        test_mode;
      logic        pgen_disable;
   } patt_ctrl_t;

   // One 32-bit write, decoded by address
   typedef union packed {
      patt_ctrl_t  ctrl;
      logic [31:0] usr;
   } patt_cfg_word_t;

   // Counter step shared by generator and checker
   // Overflow past the counter range lands on zero, not modulo
   function automatic logic [cnt_wi-1:0] cnt_next(input logic [cnt_wi-1:0] cnt,
                                                  input logic [3:0]        step);
      logic [cnt_wi:0] sum;
      sum = {1'b0, cnt} + {{(cnt_wi-3){1'b0}}, step};
      return sum[cnt_wi] ? '0 : sum[cnt_wi-1:0];
   endfunction

endpackage

// ==== src/patt_top.sv ====
`timescale 1ns/10ps

module patt_top #(
   parameter int dwi = 32
) (
   input  logic                        clk,
   input  logic                        arst_n,

   // --------------------
   // Register port
   // --------------------
   input  logic                        cfg_req,
   input  logic                        cfg_addr,
   input  patt_pkg::patt_cfg_word_t    cfg_wdata,
   output logic                        cfg_ack,

   // --------------------
   // Pattern out
   // --------------------
   output logic                        tx_valid,
   output logic [dwi-1:0]              tx_data,

   // --------------------
   // Pattern in
   // --------------------
   input  logic                        rx_valid,
   input  logic [dwi-1:0]              rx_data,
   output logic                        rx_match,
   output logic [patt_pkg::err_wi-1:0] rx_err_cnt
);

   // Rate pulse, divider to generator
   logic strobe;

   // Settings shared by all blocks
   patt_cfg_if #(.dwi(dwi)) cfg_if ();

   // Register port and field decode
   patt_cfg_regs #(.dwi(dwi)) regs_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .cfg_req   (cfg_req),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_ack   (cfg_ack),
      .cfg       (cfg_if)
   );

   // Word rate divider
   rate_strobe strobe_i (
      .clk    (clk),
      .arst_n (arst_n),
      .cfg    (cfg_if),
      .strobe (strobe)
   );

   // Source side
   patt_gen #(.dwi(dwi)) gen_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .cfg      (cfg_if),
      .strobe   (strobe),
      .tx_valid (tx_valid),
      .tx_data  (tx_data)
   );

   // Sink side
   patt_check #(.dwi(dwi)) check_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .cfg        (cfg_if),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_match   (rx_match),
      .rx_err_cnt (rx_err_cnt)
   );

endmodule

// ==== src/rate_strobe.sv ====
`timescale 1ns/10ps

module rate_strobe (
   input  logic     clk,
   input  logic     arst_n,
   // Rate and enable
   patt_cfg_if.user cfg,
   // One-cycle pulse every rate_enc cycles
   output logic     strobe
);

   // Cycles left until the next pulse, zero while idle
   logic [5:0] cnt_q;
   // Effective count, idle state picks up the current rate
   logic [5:0] remain;

   assign remain = (cnt_q == 6'd0) ? cfg.rate_enc : cnt_q;

   // --------------------
   // Down-counter
   // --------------------

   // Held at zero while disabled
   // First pulse lands rate_enc cycles after enable
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q  <= 6'd0;
         strobe <= 1'b0;
      end else if (cfg.pgen_off) begin
         cnt_q  <= 6'd0;
         strobe <= 1'b0;
      end else if (remain == 6'd1) begin
         // Expiry, pulse and reload
         cnt_q  <= cfg.rate_enc;
         strobe <= 1'b1;
      end else begin
         cnt_q  <= remain - 6'd1;
         strobe <= 1'b0;
      end
   end

endmodule

// ==== testbench/patt_top_asserts.sv ====
`timescale 1ns/10ps

module patt_top_asserts (
   input logic                        clk,
   input logic                        arst_n,
   input logic                        cfg_req,
   input logic                        cfg_ack,
   input logic                        tx_valid,
   input logic                        pgen_off,
   input logic [5:0]                  rate_enc,
   input logic [patt_pkg::err_wi-1:0] rx_err_cnt
);

   // --------------------
   // Register port
   // --------------------

   // New request only with ack low, ack answers it one cycle later
   a_ack_follows : assert property (@(posedge clk) disable iff (!arst_n)
      $rose(cfg_req) |-> !cfg_ack ##1 cfg_ack)
      else $error("cfg_ack did not answer a new cfg_req");

   // Ack drops one cycle after req drops
   a_ack_release : assert property (@(posedge clk) disable iff (!arst_n)
      $fell(cfg_req) |=> !cfg_ack)
      else $error("cfg_ack did not drop after cfg_req");

   // --------------------
   // Stream
   // --------------------

   // Slower rates leave a gap after every word
   a_valid_gap : assert property (@(posedge clk) disable iff (!arst_n)
      (tx_valid && rate_enc > 6'd1) |=> !tx_valid)
      else $error("tx_valid high on two cycles in a row");

   // Error count only moves up while enabled
   a_err_mono : assert property (@(posedge clk) disable iff (!arst_n)
      !pgen_off |=> rx_err_cnt >= $past(rx_err_cnt))
      else $error("rx_err_cnt went down while enabled");

endmodule

bind patt_top patt_top_asserts asserts_i (
   .clk        (clk),
   .arst_n     (arst_n),
   .cfg_req    (cfg_req),
   .cfg_ack    (cfg_ack),
   .tx_valid   (tx_valid),
   .pgen_off   (cfg_if.pgen_off),
   .rate_enc   (cfg_if.rate_enc),
   .rx_err_cnt (rx_err_cnt)
);

// ==== testbench/patt_top_tb.sv ====
`timescale 1ns/10ps

module patt_top_tb;
   import patt_pkg::*;

   localparam int dwi = 32;

   logic clk, arst_n, cfg_req, cfg_addr, cfg_ack, tx_valid, rx_valid, rx_match;
   patt_cfg_word_t cfg_wdata;
   logic [dwi-1:0] tx_data, rx_data;
   logic [err_wi-1:0] rx_err_cnt;

   // Parsed vector lines
   byte         v_cmd[$];
   int          v_a[$];
   logic [31:0] v_b[$];
   longint      limit_ns;
   logic        limit_ready;

   // Reference model state
   logic          m_off, m_mode, corrupt_pending, have_prev;
   logic [5:0]    m_rate;
   logic [3:0]    m_step;
   logic [6:0]    m_cnt;
   logic [dwi-1:0] m_usr, exp_prev;
   int            gap, off_cyc;
   logic [31:0]   lfsr;

   patt_top #(.dwi(dwi)) dut_i (.*);

   always #50 clk = ~clk;

   // --------------------
   // Helpers
   // --------------------

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Counter rule, sums of 128 or more land on zero
   function automatic logic [6:0] step_cnt(input logic [6:0] c, input logic [3:0] s);
      int sum;
      sum = int'(c) + int'(s);
      return (sum >= 128) ? 7'd0 : sum[6:0];
   endfunction

   task automatic abort_run();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_data(input logic [dwi-1:0] got, input logic [dwi-1:0] exp);
      if (got !== exp) begin
         $display("Fail tx_data got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   task automatic check_match(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail rx_match got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   task automatic check_err_cnt(input logic [err_wi-1:0] got, input logic [err_wi-1:0] exp);
      if (got !== exp) begin
         $display("Fail rx_err_cnt got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   task automatic check_ack(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail cfg_ack got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   // Checks this cycle's tx side and drives the loopback
   task automatic observe_tx();
      int bit_idx;
      off_cyc = m_off ? off_cyc + 1 : 0;
      if (m_off) begin
         have_prev = 1'b0;
      end
      if (tx_valid) begin
         if (off_cyc > 1) begin
            $display("tx_valid still pulsing after the generator was disabled");
            abort_run();
         end
         check_data(tx_data, exp_prev);
         if (have_prev && gap != int'(m_rate)) begin
            $display("Word spacing was %0d cycles instead of %0d", gap, m_rate);
            abort_run();
         end
         have_prev = 1'b1;
         gap = 0;
      end
      gap++;
      // Word the generator would load if it fired now
      exp_prev = (m_mode == tmode_usr) ? m_usr : dwi'(m_cnt);
      m_cnt = m_off ? 7'd0 : (tx_valid ? step_cnt(m_cnt, m_step) : m_cnt);
      rx_valid = tx_valid;
      rx_data  = tx_data;
      if (tx_valid && corrupt_pending) begin
         // Bits 8..23, never a legal counter value
         bit_idx = 8;
         for (int i = 0; i < 4; i++) begin
            lfsr = lfsr_step(lfsr);
            bit_idx += int'(lfsr[0]) << i;
         end
         rx_data[bit_idx] = ~rx_data[bit_idx];
         corrupt_pending = 1'b0;
      end
   endtask

   task automatic do_write(input logic addr, input logic [31:0] data);
      patt_cfg_word_t w;
      w = data;
      cfg_req   = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = w;
      @(negedge clk);
      check_ack(cfg_ack, 1'b1);
      // Settings take effect in the ack cycle
      have_prev = 1'b0;
      if (addr == addr_ctrl) begin
         m_off  = w.ctrl.pgen_disable;
         m_mode = w.ctrl.test_mode;
         m_rate = (w.ctrl.rate == 5'd0) ? 6'd32 : {1'b0, w.ctrl.rate};
         m_step = (w.ctrl.inc_step == 3'd0) ? 4'd8 : {1'b0, w.ctrl.inc_step};
      end else begin
         m_usr = dwi'(data);
      end
      observe_tx();
      cfg_req = 1'b0;
      @(negedge clk);
      check_ack(cfg_ack, 1'b0);
      observe_tx();
   endtask

   // --------------------
   // Main sequence
   // --------------------

   initial begin
      int fd, n;
      string line;
      byte c;
      int a;
      logic [31:0] b;
      longint cycles;
      clk = 1'b0;
      arst_n = 1'b0;
      cfg_req = 1'b0;
      cfg_addr = 1'b0;
      cfg_wdata = '0;
      rx_valid = 1'b0;
      rx_data = '0;
      limit_ready = 1'b0;
      m_off = 1'b1;
      m_mode = tmode_cnt;
      m_rate = 6'd1;
      m_step = 4'd1;
      m_cnt = '0;
      m_usr = '0;
      exp_prev = '0;
      gap = 0;
      off_cyc = 0;
      have_prev = 1'b0;
      corrupt_pending = 1'b0;
      lfsr = 32'h7b601cec;
      fd = $fopen("testbench/patt_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file");
         abort_run();
      end
      cycles = 100;
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%c %d %h", c, a, b);
            if (n != 3) begin
               $display("Malformed line in the vector file");
               abort_run();
            end
            v_cmd.push_back(c);
            v_a.push_back(a);
            v_b.push_back(b);
            cycles += (c == "r") ? a : 3;
         end
      end
      $fclose(fd);
      limit_ns = cycles * 100;
      limit_ready = 1'b1;
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      foreach (v_cmd[i]) begin
         case (v_cmd[i])
            "w": do_write(v_a[i][0], v_b[i]);
            "r": repeat (v_a[i]) begin
               @(negedge clk);
               observe_tx();
            end
            "c": corrupt_pending = 1'b1;
            "e": begin
               check_match(rx_match, v_a[i][0]);
               check_err_cnt(rx_err_cnt, v_b[i][err_wi-1:0]);
            end
            default: begin
               $display("Unknown command in the vector file");
               abort_run();
            end
         endcase
      end
      $display("Test passed");
      $finish;
   end

   // Watchdog sized from the vector file
   initial begin
      wait (limit_ready);
      #(limit_ns);
      $display("Simulation ran past its time limit");
      $display("Test failed");
      $fatal(1);
   end

endmodule

// ==== testbench/patt_vectors.txt ====
# cmd a b : w addr data | r cycles 0 | c 0 0 flips a bit of the next rx word
# e match err_cnt : expected status at that point
w 0 00000004
r 60 0
e 1 0
c 0 0
r 2 0
e 0 1
r 40 0
e 1 1
w 0 00000001
r 4 0
e 0 0
w 0 00000180
r 300 0
e 1 0
w 0 00000001
w 1 a5c30f1e
w 0 0000008e
r 60 0
e 1 0
w 0 00000001
r 4 0
e 0 0
